// File: skdecode_ctrl.sv
// Decode control: read and write FSMs, address counters, section flags, done and error status
`timescale 1ns/10ps

module skdecode_ctrl (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 zeroize,
    input  logic                                 skdecode_enable,
    input  logic [skdecode_pkg::addr_width-1:0]  src_base_addr,
    input  logic [skdecode_pkg::addr_width-1:0]  dest_base_addr,
    input  logic                                 s1s2_valid,
    input  logic                                 t0_valid,
    input  logic                                 s1s2_error,
    output skdecode_pkg::mem_req_t               kmem_a_rd_req,
    output skdecode_pkg::mem_req_t               kmem_b_rd_req,
    output skdecode_pkg::mem_req_t               mem_a_wr_req,
    output skdecode_pkg::mem_req_t               mem_b_wr_req,
    output logic                                 s1s2_enable,
    output logic                                 t0_enable,
    output logic                                 s1s2_mode,
    output logic                                 t0_mode,
    output logic                                 rd_parity,
    output logic                                 skdecode_done,
    output logic                                 s1_done,
    output logic                                 s2_done,
    output logic                                 t0_done,
    output logic                                 skdecode_error
);
    import skdecode_pkg::*;

    skdec_rd_state_e       rd_state;
    skdec_rd_state_e       rd_state_nxt;
    skdec_wr_state_e       wr_state;
    skdec_wr_state_e       wr_state_nxt;
    logic [8:0]            rd_count;
    logic [8:0]            rd_last_count;
    logic                  rd_last;
    logic                  rd_active;
    logic                  s1s2_enable_fsm;
    logic                  t0_enable_fsm;
    logic [addr_width-1:0] kmem_rd_addr;
    logic [addr_width-1:0] wr_addr;
    logic [addr_width-1:0] dest_base_q;
    logic                  wr_s1s2_fire;
    logic                  wr_t0_fire;
    logic                  start;

    // --------------------
    // Read FSM
    // --------------------
    always_comb begin
        start           = skdecode_enable && (wr_state == SKDEC_WR_IDLE);
        s1s2_enable_fsm = (rd_state == SKDEC_RD_S1) || (rd_state == SKDEC_RD_S2);
        t0_enable_fsm   = (rd_state == SKDEC_RD_T0);
        rd_active       = s1s2_enable_fsm || t0_enable_fsm;
        case (rd_state)
            SKDEC_RD_S1: rd_last_count = 9'(s1_reads - 1);
            SKDEC_RD_S2: rd_last_count = 9'(s2_reads - 1);
            default:     rd_last_count = 9'(t0_reads - 1);
        endcase
        rd_last = rd_active && (rd_count == rd_last_count);
    end

    // Next section is chosen once the write side has drained into STAGE
    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            SKDEC_RD_IDLE: begin
                if (skdecode_enable)
                    rd_state_nxt = SKDEC_RD_S1;
            end
            SKDEC_RD_S1, SKDEC_RD_S2, SKDEC_RD_T0: begin
                if (rd_last)
                    rd_state_nxt = SKDEC_RD_STAGE;
            end
            SKDEC_RD_STAGE: begin
                if (wr_state == SKDEC_WR_STAGE)
                    rd_state_nxt = t0_done ? SKDEC_RD_IDLE :
                                   s2_done ? SKDEC_RD_T0 : SKDEC_RD_S2;
            end
            default: rd_state_nxt = SKDEC_RD_IDLE;
        endcase
    end

    // --------------------
    // Write FSM
    // --------------------
    // A section is drained when valid falls while the read side waits in STAGE
    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            SKDEC_WR_IDLE: begin
                if (skdecode_enable)
                    wr_state_nxt = SKDEC_WR_S1;
            end
            SKDEC_WR_S1, SKDEC_WR_S2: begin
                if ((rd_state == SKDEC_RD_STAGE) && !s1s2_valid)
                    wr_state_nxt = SKDEC_WR_STAGE;
            end
            SKDEC_WR_T0: begin
                if ((rd_state == SKDEC_RD_STAGE) && !t0_valid)
                    wr_state_nxt = SKDEC_WR_STAGE;
            end
            SKDEC_WR_STAGE: begin
                wr_state_nxt = t0_done ? SKDEC_WR_IDLE :
                               s2_done ? SKDEC_WR_T0 : SKDEC_WR_S2;
            end
            default: wr_state_nxt = SKDEC_WR_IDLE;
        endcase
    end

    // Range error aborts both machines
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state <= SKDEC_RD_IDLE;
            wr_state <= SKDEC_WR_IDLE;
        end else if (zeroize || s1s2_error) begin
            rd_state <= SKDEC_RD_IDLE;
            wr_state <= SKDEC_WR_IDLE;
        end else begin
            rd_state <= rd_state_nxt;
            wr_state <= wr_state_nxt;
        end
    end

    // --------------------
    // Address counters
    // --------------------
    // Read address runs on through s1, s2 and into t0 at src + 480
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_count     <= '0;
            kmem_rd_addr <= '0;
        end else if (zeroize) begin
            rd_count     <= '0;
            kmem_rd_addr <= '0;
        end else if (start) begin
            rd_count     <= '0;
            kmem_rd_addr <= src_base_addr;
        end else if (rd_active) begin
            rd_count     <= rd_last ? 9'd0 : rd_count + 9'd1;
            kmem_rd_addr <= kmem_rd_addr + (t0_enable_fsm ? addr_width'(2) : addr_width'(1));
        end
    end

    always_comb begin
        s1s2_mode    = (wr_state == SKDEC_WR_S1) || (wr_state == SKDEC_WR_S2);
        t0_mode      = (wr_state == SKDEC_WR_T0);
        wr_s1s2_fire = s1s2_mode && s1s2_valid && !s1s2_error;
        wr_t0_fire   = t0_mode && t0_valid;
    end

    // Two words per s1/s2 pair, one word per t0 step
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr     <= '0;
            dest_base_q <= '0;
        end else if (zeroize) begin
            wr_addr     <= '0;
            dest_base_q <= '0;
        end else if (start) begin
            wr_addr     <= dest_base_addr;
            dest_base_q <= dest_base_addr;
        end else if ((wr_state == SKDEC_WR_STAGE) && (wr_state_nxt == SKDEC_WR_T0)) begin
            wr_addr <= dest_base_q + addr_width'(t0_dest_offset);
        end else if (wr_s1s2_fire) begin
            wr_addr <= wr_addr + addr_width'(2);
        end else if (wr_t0_fire) begin
            wr_addr <= wr_addr + addr_width'(1);
        end
    end

    // Enables and parity line up with data returning from the key memory
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1s2_enable <= 1'b0;
            t0_enable   <= 1'b0;
            rd_parity   <= 1'b0;
        end else if (zeroize || s1s2_error) begin
            s1s2_enable <= 1'b0;
            t0_enable   <= 1'b0;
            rd_parity   <= 1'b0;
        end else begin
            s1s2_enable <= s1s2_enable_fsm;
            t0_enable   <= t0_enable_fsm;
            rd_parity   <= kmem_rd_addr[0];
        end
    end

    // --------------------
    // Memory requests
    // --------------------
    always_comb begin
        kmem_a_rd_req.addr     = kmem_rd_addr;
        kmem_b_rd_req.addr     = t0_enable_fsm ? kmem_rd_addr + addr_width'(1) : kmem_rd_addr;
        kmem_a_rd_req.rd_wr_en = (t0_enable_fsm || (s1s2_enable_fsm && !kmem_rd_addr[0])) ?
                                 RW_READ : RW_IDLE;
        kmem_b_rd_req.rd_wr_en = (t0_enable_fsm || (s1s2_enable_fsm && kmem_rd_addr[0])) ?
                                 RW_READ : RW_IDLE;

        // t0 words go to whichever port matches the address parity
        mem_a_wr_req.addr      = wr_addr;
        mem_b_wr_req.addr      = s1s2_mode ? wr_addr + addr_width'(1) : wr_addr;
        mem_a_wr_req.rd_wr_en  = (wr_s1s2_fire || (wr_t0_fire && !wr_addr[0])) ?
                                 RW_WRITE : RW_IDLE;
        mem_b_wr_req.rd_wr_en  = (wr_s1s2_fire || (wr_t0_fire && wr_addr[0])) ?
                                 RW_WRITE : RW_IDLE;
    end

    // --------------------
    // Status
    // --------------------
    assign skdecode_done = (wr_state == SKDEC_WR_IDLE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_done <= 1'b0;
            s2_done <= 1'b0;
            t0_done <= 1'b0;
        end else if (zeroize || start) begin
            s1_done <= 1'b0;
            s2_done <= 1'b0;
            t0_done <= 1'b0;
        end else if (wr_state_nxt == SKDEC_WR_STAGE) begin
            if (wr_state == SKDEC_WR_S1)
                s1_done <= 1'b1;
            if (wr_state == SKDEC_WR_S2)
                s2_done <= 1'b1;
            if (wr_state == SKDEC_WR_T0)
                t0_done <= 1'b1;
        end
    end

    // Sticky until the next start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            skdecode_error <= 1'b0;
        else if (zeroize)
            skdecode_error <= 1'b0;
        else if (s1s2_error)
            skdecode_error <= 1'b1;
        else if (skdecode_enable)
            skdecode_error <= 1'b0;
    end

endmodule

// File: skdecode_pkg.sv
// Secret-key decode package: parameter set, key and coefficient word types, requests, FSM states
package skdecode_pkg;

    // --------------------
    // Parameter set
    // --------------------
    localparam int skdec_l    = 7;
    localparam int skdec_k    = 8;
    localparam int skdec_n    = 256;
    localparam int addr_width = 14;
    localparam int coef_width = 24;

    localparam logic [coef_width-1:0] skdec_q       = 24'd8380417;
    localparam logic [coef_width-1:0] skdec_eta     = 24'd2;
    localparam logic [coef_width-1:0] skdec_t0_half = 24'd4096;

    // Read steps per section, eight s1/s2 lanes or four t0 lanes per step
    localparam int s1_reads = skdec_l * skdec_n / 8;
    localparam int s2_reads = skdec_k * skdec_n / 8;
    localparam int t0_reads = skdec_k * skdec_n / 4;

    // Each s1/s2 step fills two destination words
    localparam int t0_dest_offset = 2 * (s1_reads + s2_reads);

    // --------------------
    // Data types
    // --------------------
    // One key memory word, read either as eight 3-bit or two 13-bit values
    typedef union packed {
        struct packed {
            logic [7:0][2:0] lane;
            logic [7:0]      pad;
        } s1s2;
        struct packed {
            logic [1:0][12:0] lane;
            logic [5:0]       pad;
        } t0;
    } key_word_u;

    // One destination word of four field coefficients
    typedef struct packed {
        logic [3:0][coef_width-1:0] coef;
    } coef_word_t;

    typedef enum logic [1:0] {
        RW_IDLE,
        RW_READ,
        RW_WRITE
    } mem_rw_e;

    typedef struct packed {
        mem_rw_e               rd_wr_en;
        logic [addr_width-1:0] addr;
    } mem_req_t;

    // --------------------
    // FSM states
    // --------------------
    typedef enum logic [2:0] {
        SKDEC_RD_IDLE,
        SKDEC_RD_S1,
        SKDEC_RD_S2,
        SKDEC_RD_T0,
        SKDEC_RD_STAGE
    } skdec_rd_state_e;

    typedef enum logic [2:0] {
        SKDEC_WR_IDLE,
        SKDEC_WR_S1,
        SKDEC_WR_S2,
        SKDEC_WR_T0,
        SKDEC_WR_STAGE
    } skdec_wr_state_e;

endpackage

// File: skdecode_s1s2_unpack.sv
// s1/s2 unpacker: eight 3-bit lanes to field coefficients, with range check
`timescale 1ns/10ps

module skdecode_s1s2_unpack (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  logic                     s1s2_enable,
    input  skdecode_pkg::key_word_u  kmem_a_rd_data,
    input  skdecode_pkg::key_word_u  kmem_b_rd_data,
    input  logic                     rd_parity,
    output logic                     s1s2_valid,
    output logic                     s1s2_error,
    output skdecode_pkg::coef_word_t coef_lo,
    output skdecode_pkg::coef_word_t coef_hi
);
    import skdecode_pkg::*;

    key_word_u                  key_word;
    logic [coef_width-1:0]      lane_val;
    logic [7:0][coef_width-1:0] coef_nxt;
    logic                       range_err;

    // Odd addresses were read on port b
    always_comb begin
        key_word  = rd_parity ? kmem_b_rd_data : kmem_a_rd_data;
        range_err = 1'b0;
        for (int i = 0; i < 8; i++) begin
            lane_val    = coef_width'(key_word.s1s2.lane[i]);
            // eta - x, wrapped into the field when negative
            coef_nxt[i] = (lane_val > skdec_eta) ? skdec_q + skdec_eta - lane_val :
                                                   skdec_eta - lane_val;
            if (key_word.s1s2.lane[i] > 3'd4)
                range_err = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1s2_valid <= 1'b0;
            s1s2_error <= 1'b0;
        end else if (zeroize) begin
            s1s2_valid <= 1'b0;
            s1s2_error <= 1'b0;
        end else begin
            s1s2_valid <= s1s2_enable;
            s1s2_error <= s1s2_enable && range_err;
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize) begin
            coef_lo <= '0;
            coef_hi <= '0;
        end else if (s1s2_enable) begin
            coef_lo.coef <= coef_nxt[3:0];
            coef_hi.coef <= coef_nxt[7:4];
        end
    end

endmodule

// File: skdecode_t0_unpack.sv
// t0 unpacker: four 13-bit lanes from two key words to one coefficient word
`timescale 1ns/10ps

module skdecode_t0_unpack (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  logic                     t0_enable,
    input  skdecode_pkg::key_word_u  kmem_a_rd_data,
    input  skdecode_pkg::key_word_u  kmem_b_rd_data,
    output logic                     t0_valid,
    output skdecode_pkg::coef_word_t t0_coef
);
    import skdecode_pkg::*;

    logic [3:0][coef_width-1:0] lane_val;
    coef_word_t                 coef_nxt;

    // Port a holds coefficients 0 and 1, port b holds 2 and 3
    always_comb begin
        lane_val[0] = coef_width'(kmem_a_rd_data.t0.lane[0]);
        lane_val[1] = coef_width'(kmem_a_rd_data.t0.lane[1]);
        lane_val[2] = coef_width'(kmem_b_rd_data.t0.lane[0]);
        lane_val[3] = coef_width'(kmem_b_rd_data.t0.lane[1]);
        for (int i = 0; i < 4; i++) begin
            coef_nxt.coef[i] = (lane_val[i] > skdec_t0_half) ?
                               skdec_q + skdec_t0_half - lane_val[i] :
                               skdec_t0_half - lane_val[i];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            t0_valid <= 1'b0;
        else if (zeroize)
            t0_valid <= 1'b0;
        else
            t0_valid <= t0_enable;
    end

    always_ff @(posedge clk) begin
        if (zeroize)
            t0_coef <= '0;
        else if (t0_enable)
            t0_coef <= coef_nxt;
    end

endmodule

// File: skdecode_tb.sv
// Testbench for the secret-key decode engine: memory models, reference model, directed tests
`timescale 1ns/10ps

module skdecode_tb;
    import skdecode_pkg::*;

    localparam int max_cycles    = 8000;
    localparam int decode_limit  = 2000;
    localparam int dest_words    = 1472;
    localparam int t0_start_word = 960;
    localparam int t0_key_offset = 480;
    localparam logic [23:0] field_q = 24'd8380417;

    logic                  clk;
    logic                  reset_n;
    logic                  zeroize;
    logic                  skdecode_enable;
    logic [addr_width-1:0] src_base_addr;
    logic [addr_width-1:0] dest_base_addr;
    mem_req_t              kmem_a_rd_req;
    mem_req_t              kmem_b_rd_req;
    key_word_u             kmem_a_rd_data;
    key_word_u             kmem_b_rd_data;
    mem_req_t              mem_a_wr_req;
    mem_req_t              mem_b_wr_req;
    coef_word_t            mem_a_wr_data;
    coef_word_t            mem_b_wr_data;
    logic                  skdecode_done;
    logic                  s1_done;
    logic                  s2_done;
    logic                  t0_done;
    logic                  skdecode_error;

    logic [31:0] key_mem [0:2047];
    logic [95:0] dest_mem [0:16383];
    logic        dest_written [0:16383];
    int          write_count;
    int          cycle_count;
    int          error_count;
    int          test_count;
    int          failed_tests;
    logic [31:0] lcg_state;

    skdecode_top dut (.*);

    always #4 clk = ~clk;

    // --------------------
    // Memory models
    // --------------------
    always @(posedge clk) begin
        if (kmem_a_rd_req.rd_wr_en == RW_READ)
            kmem_a_rd_data <= key_mem[kmem_a_rd_req.addr[10:0]];
        if (kmem_b_rd_req.rd_wr_en == RW_READ)
            kmem_b_rd_data <= key_mem[kmem_b_rd_req.addr[10:0]];
    end

    always @(posedge clk) begin
        if (mem_a_wr_req.rd_wr_en == RW_WRITE) begin
            dest_mem[mem_a_wr_req.addr]     <= mem_a_wr_data;
            dest_written[mem_a_wr_req.addr] <= 1'b1;
        end
        if (mem_b_wr_req.rd_wr_en == RW_WRITE) begin
            dest_mem[mem_b_wr_req.addr]     <= mem_b_wr_data;
            dest_written[mem_b_wr_req.addr] <= 1'b1;
        end
        write_count <= write_count + int'(mem_a_wr_req.rd_wr_en == RW_WRITE)
                                   + int'(mem_b_wr_req.rd_wr_en == RW_WRITE);
    end

    // Five full decodes of about 1000 cycles plus margin
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Checks failed");
            $display("Timeout after %0d cycles", cycle_count);
            $finish;
        end
    end

    // --------------------
    // Stimulus and reference model
    // --------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // s1/s2 lanes folded into 0..4
    task automatic fill_key_mem();
        logic [31:0] w;
        for (int a = 0; a < 2048; a++) begin
            w = lcg_next() ^ {a[10:0], 10'd0, a[10:0]};
            for (int i = 0; i < 8; i++)
                if (w[8 + 3*i +: 3] > 3'd4)
                    w[8 + 3*i +: 3] = w[8 + 3*i +: 3] - 3'd4;
            key_mem[a] = w;
        end
    endtask

    function automatic logic [23:0] s1s2_field(logic [2:0] x);
        logic [23:0] v;
        v = 24'(x);
        return (v <= 24'd2) ? 24'd2 - v : field_q + 24'd2 - v;
    endfunction

    function automatic logic [23:0] t0_field(logic [12:0] x);
        logic [23:0] v;
        v = 24'(x);
        return (v <= 24'd4096) ? 24'd4096 - v : field_q + 24'd4096 - v;
    endfunction

    // Expected destination word idx, counted from the destination base
    function automatic logic [95:0] ref_word(int src, int idx);
        logic [31:0] wa;
        logic [31:0] wb;
        logic [95:0] w;
        int          r;
        int          half;
        if (idx < t0_start_word) begin
            r    = idx / 2;
            half = idx % 2;
            wa   = key_mem[src + r];
            for (int j = 0; j < 4; j++)
                w[24*j +: 24] = s1s2_field(wa[8 + 3*(4*half + j) +: 3]);
        end else begin
            r  = idx - t0_start_word;
            wa = key_mem[src + t0_key_offset + 2*r];
            wb = key_mem[src + t0_key_offset + 2*r + 1];
            w[23:0]  = t0_field(wa[18:6]);
            w[47:24] = t0_field(wa[31:19]);
            w[71:48] = t0_field(wb[18:6]);
            w[95:72] = t0_field(wb[31:19]);
        end
        return w;
    endfunction

    // --------------------
    // Helpers
    // --------------------
    task automatic report_mismatch(string name, logic [95:0] expected, logic [95:0] actual);
        $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic report_test(string name, int errors_before);
        test_count++;
        if (error_count != errors_before)
            failed_tests++;
        $display("test %s: %0d errors", name, error_count - errors_before);
    endtask

    task automatic clear_dest_mem();
        for (int a = 0; a < 16384; a++) begin
            dest_mem[a]     = '0;
            dest_written[a] = 1'b0;
        end
        write_count = 0;
    endtask

    task automatic run_decode(int src, int dest);
        int n;
        n = 0;
        @(posedge clk);
        src_base_addr   <= addr_width'(src);
        dest_base_addr  <= addr_width'(dest);
        skdecode_enable <= 1'b1;
        @(posedge clk);
        skdecode_enable <= 1'b0;
        @(negedge clk);
        while (!skdecode_done && n < decode_limit) begin
            @(negedge clk);
            n++;
        end
        if (!skdecode_done) begin
            $display("Decode did not finish within %0d cycles", decode_limit);
            error_count++;
        end
    endtask

    task automatic verify_dest(int src, int dest);
        for (int i = 0; i < dest_words; i++) begin
            if (!dest_written[dest + i]) begin
                $display("Destination word %0d was never written", dest + i);
                error_count++;
            end else if (dest_mem[dest + i] !== ref_word(src, i))
                report_mismatch($sformatf("dest_mem[%0d]", dest + i),
                                ref_word(src, i), dest_mem[dest + i]);
        end
        for (int a = 0; a < 16384; a++) begin
            if (dest_written[a] && (a < dest || a >= dest + dest_words)) begin
                $display("Write outside the destination range at word %0d", a);
                error_count++;
            end
        end
        if (write_count !== dest_words)
            report_mismatch("write_count", dest_words, write_count);
    endtask

    task automatic check_cleared_state();
        if (kmem_a_rd_req.rd_wr_en !== RW_IDLE)
            report_mismatch("kmem_a_rd_req.rd_wr_en", RW_IDLE, kmem_a_rd_req.rd_wr_en);
        if (kmem_b_rd_req.rd_wr_en !== RW_IDLE)
            report_mismatch("kmem_b_rd_req.rd_wr_en", RW_IDLE, kmem_b_rd_req.rd_wr_en);
        if (mem_a_wr_req.rd_wr_en !== RW_IDLE)
            report_mismatch("mem_a_wr_req.rd_wr_en", RW_IDLE, mem_a_wr_req.rd_wr_en);
        if (mem_b_wr_req.rd_wr_en !== RW_IDLE)
            report_mismatch("mem_b_wr_req.rd_wr_en", RW_IDLE, mem_b_wr_req.rd_wr_en);
        if (s1_done !== 1'b0)
            report_mismatch("s1_done", 0, s1_done);
        if (s2_done !== 1'b0)
            report_mismatch("s2_done", 0, s2_done);
        if (t0_done !== 1'b0)
            report_mismatch("t0_done", 0, t0_done);
        if (skdecode_error !== 1'b0)
            report_mismatch("skdecode_error", 0, skdecode_error);
        if (skdecode_done !== 1'b1)
            report_mismatch("skdecode_done", 1, skdecode_done);
    endtask

    task automatic check_all_done();
        if (s1_done !== 1'b1)
            report_mismatch("s1_done", 1, s1_done);
        if (s2_done !== 1'b1)
            report_mismatch("s2_done", 1, s2_done);
        if (t0_done !== 1'b1)
            report_mismatch("t0_done", 1, t0_done);
        if (skdecode_error !== 1'b0)
            report_mismatch("skdecode_error", 0, skdecode_error);
        if (skdecode_done !== 1'b1)
            report_mismatch("skdecode_done", 1, skdecode_done);
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_state();
        int errs;
        errs = error_count;
        @(negedge clk);
        check_cleared_state();
        report_test("reset state", errs);
    endtask

    task automatic test_full_decode();
        int errs;
        errs = error_count;
        clear_dest_mem();
        run_decode(0, 0);
        verify_dest(0, 0);
        check_all_done();
        report_test("full decode", errs);
    endtask

    task automatic test_offset_decode();
        int errs;
        errs = error_count;
        clear_dest_mem();
        run_decode(64, 100);
        verify_dest(64, 100);
        check_all_done();
        report_test("offset decode", errs);
    endtask

    // Lane 3 of an s2 key word set out of range
    task automatic test_range_error();
        int          errs;
        logic [31:0] saved;
        errs  = error_count;
        saved = key_mem[300];
        key_mem[300][19:17] = 3'd6;
        clear_dest_mem();
        run_decode(0, 0);
        if (skdecode_error !== 1'b1)
            report_mismatch("skdecode_error", 1, skdecode_error);
        if (skdecode_done !== 1'b1)
            report_mismatch("skdecode_done", 1, skdecode_done);
        if (s2_done !== 1'b0)
            report_mismatch("s2_done", 0, s2_done);
        if (t0_done !== 1'b0)
            report_mismatch("t0_done", 0, t0_done);
        for (int i = t0_start_word; i < dest_words; i++) begin
            if (dest_written[i]) begin
                $display("t0 word %0d was written after the range error", i);
                error_count++;
            end
        end
        key_mem[300] = saved;
        report_test("range error", errs);
    endtask

    task automatic test_zeroize();
        int errs;
        int n;
        errs = error_count;
        n    = 0;
        clear_dest_mem();
        @(posedge clk);
        src_base_addr   <= '0;
        dest_base_addr  <= '0;
        skdecode_enable <= 1'b1;
        @(posedge clk);
        skdecode_enable <= 1'b0;
        @(negedge clk);
        while (!s1_done && n < decode_limit) begin
            @(negedge clk);
            n++;
        end
        if (!s1_done) begin
            $display("s1 section did not finish before zeroize");
            error_count++;
        end
        // Well into s2
        repeat (20) @(negedge clk);
        @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        @(negedge clk);
        check_cleared_state();
        clear_dest_mem();
        run_decode(0, 0);
        verify_dest(0, 0);
        check_all_done();
        report_test("zeroize", errs);
    endtask

    initial begin
        clk             = 1'b0;
        reset_n         = 1'b0;
        zeroize         = 1'b0;
        skdecode_enable = 1'b0;
        src_base_addr   = '0;
        dest_base_addr  = '0;
        kmem_a_rd_data  = '0;
        kmem_b_rd_data  = '0;
        write_count     = 0;
        cycle_count     = 0;
        error_count     = 0;
        test_count      = 0;
        failed_tests    = 0;
        lcg_state       = 32'd85519;
        fill_key_mem();
        clear_dest_mem();
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        test_reset_state();
        test_full_decode();
        test_offset_decode();
        test_range_error();
        test_zeroize();

        $display("%0d tests, %0d failed, %0d errors, %0d cycles",
                 test_count, failed_tests, error_count, cycle_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: skdecode_top.sv
// Secret-key decode top level: control FSMs, s1/s2 and t0 unpackers, write steering
`timescale 1ns/10ps

module skdecode_top (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize,
    input  logic                                skdecode_enable,
    input  logic [skdecode_pkg::addr_width-1:0] src_base_addr,
    input  logic [skdecode_pkg::addr_width-1:0] dest_base_addr,
    output skdecode_pkg::mem_req_t              kmem_a_rd_req,
    output skdecode_pkg::mem_req_t              kmem_b_rd_req,
    input  skdecode_pkg::key_word_u             kmem_a_rd_data,
    input  skdecode_pkg::key_word_u             kmem_b_rd_data,
    output skdecode_pkg::mem_req_t              mem_a_wr_req,
    output skdecode_pkg::mem_req_t              mem_b_wr_req,
    output skdecode_pkg::coef_word_t            mem_a_wr_data,
    output skdecode_pkg::coef_word_t            mem_b_wr_data,
    output logic                                skdecode_done,
    output logic                                s1_done,
    output logic                                s2_done,
    output logic                                t0_done,
    output logic                                skdecode_error
);
    import skdecode_pkg::*;

    logic       s1s2_enable;
    logic       t0_enable;
    logic       s1s2_mode;
    logic       t0_mode;
    logic       rd_parity;
    logic       s1s2_valid;
    logic       s1s2_error;
    logic       t0_valid;
    coef_word_t coef_lo;
    coef_word_t coef_hi;
    coef_word_t t0_coef;

    skdecode_ctrl u_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .skdecode_enable (skdecode_enable),
        .src_base_addr   (src_base_addr),
        .dest_base_addr  (dest_base_addr),
        .s1s2_valid      (s1s2_valid),
        .t0_valid        (t0_valid),
        .s1s2_error      (s1s2_error),
        .kmem_a_rd_req   (kmem_a_rd_req),
        .kmem_b_rd_req   (kmem_b_rd_req),
        .mem_a_wr_req    (mem_a_wr_req),
        .mem_b_wr_req    (mem_b_wr_req),
        .s1s2_enable     (s1s2_enable),
        .t0_enable       (t0_enable),
        .s1s2_mode       (s1s2_mode),
        .t0_mode         (t0_mode),
        .rd_parity       (rd_parity),
        .skdecode_done   (skdecode_done),
        .s1_done         (s1_done),
        .s2_done         (s2_done),
        .t0_done         (t0_done),
        .skdecode_error  (skdecode_error)
    );

    skdecode_s1s2_unpack u_s1s2_unpack (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .s1s2_enable    (s1s2_enable),
        .kmem_a_rd_data (kmem_a_rd_data),
        .kmem_b_rd_data (kmem_b_rd_data),
        .rd_parity      (rd_parity),
        .s1s2_valid     (s1s2_valid),
        .s1s2_error     (s1s2_error),
        .coef_lo        (coef_lo),
        .coef_hi        (coef_hi)
    );

    skdecode_t0_unpack u_t0_unpack (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .t0_enable      (t0_enable),
        .kmem_a_rd_data (kmem_a_rd_data),
        .kmem_b_rd_data (kmem_b_rd_data),
        .t0_valid       (t0_valid),
        .t0_coef        (t0_coef)
    );

    skdecode_wr_steer u_wr_steer (
        .s1s2_mode     (s1s2_mode),
        .t0_mode       (t0_mode),
        .mem_a_wr_req  (mem_a_wr_req),
        .coef_lo       (coef_lo),
        .coef_hi       (coef_hi),
        .t0_coef       (t0_coef),
        .mem_a_wr_data (mem_a_wr_data),
        .mem_b_wr_data (mem_b_wr_data)
    );

endmodule

// File: skdecode_wr_steer.sv
// Write steering: routes the active unpacker's coefficient words to destination ports
`timescale 1ns/10ps

module skdecode_wr_steer (
    input  logic                     s1s2_mode,
    input  logic                     t0_mode,
    input  skdecode_pkg::mem_req_t   mem_a_wr_req,
    input  skdecode_pkg::coef_word_t coef_lo,
    input  skdecode_pkg::coef_word_t coef_hi,
    input  skdecode_pkg::coef_word_t t0_coef,
    output skdecode_pkg::coef_word_t mem_a_wr_data,
    output skdecode_pkg::coef_word_t mem_b_wr_data
);
    import skdecode_pkg::*;

    // Zero unless a section is writing
    always_comb begin
        mem_a_wr_data = '0;
        mem_b_wr_data = '0;
        if (t0_mode) begin
            // Request parity decides which port actually writes
            mem_a_wr_data = t0_coef;
            mem_b_wr_data = t0_coef;
        end else if (s1s2_mode && (mem_a_wr_req.rd_wr_en == RW_WRITE)) begin
            mem_a_wr_data = coef_lo;
            mem_b_wr_data = coef_hi;
        end
    end

endmodule

// File: src.f
skdecode_pkg.sv
skdecode_ctrl.sv
skdecode_s1s2_unpack.sv
skdecode_t0_unpack.sv
skdecode_wr_steer.sv
skdecode_top.sv
skdecode_tb.sv
